// ==== common/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    // Datapath words and register indices
    typedef logic [31:0] word;
    typedef logic [4:0] regAddr;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluXor = 3'd4,
        aluSlt = 3'd5,
        aluLui = 3'd6
    } aluOp;

    // What the Memory stage writes back
    typedef enum logic [1:0] {
        wbNone = 2'd0,
        wbAlu  = 2'd1,
        wbMem  = 2'd2
    } wbSrc;

    typedef enum logic [1:0] {
        fetchIdle    = 2'd0,
        fetchRequest = 2'd1,
        fetchHold    = 2'd2
    } fetchState;

    // Primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // Function field of SPECIAL
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnSlt  = 6'h2a;

endpackage

`default_nettype wire

// ==== hw/fetch/instFetch.sv ====
`default_nettype none
`timescale 1ns/1ns

module instFetch #(
    parameter cpuPkg::word resetPc = 32'hBFC00000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        redirect,
    input  cpuPkg::word redirectAddr,
    input  logic        decodeStall,
    output cpuPkg::word instAddr,
    output logic        instReadEn,
    input  cpuPkg::word instData,
    input  logic        instValid,
    output cpuPkg::word fetchInst,
    output cpuPkg::word fetchPc,
    output logic        fetchValid
);

    cpuPkg::fetchState state;
    cpuPkg::word pc;
    cpuPkg::word target;
    cpuPkg::word holdInst;
    cpuPkg::word holdPc;
    cpuPkg::word pendingAddr;
    logic pendingRedirect;
    logic done;

    assign instAddr = pc;
    // Idle issues a request only when Decode can move on
    assign instReadEn = (state == cpuPkg::fetchRequest) ||
                        (state == cpuPkg::fetchIdle && !decodeStall);
    assign done = instReadEn && instValid;

    // Redirect applies after the delay-slot word completes
    always_comb begin
        if (pendingRedirect) begin
            target = pendingAddr;
        end else if (redirect) begin
            target = redirectAddr;
        end else begin
            target = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cpuPkg::fetchIdle;
            pc <= resetPc;
            pendingRedirect <= 1'b0;
            fetchValid <= 1'b0;
        end else if (state == cpuPkg::fetchHold) begin
            if (!decodeStall) begin
                state <= cpuPkg::fetchIdle;
                fetchValid <= 1'b1;
                // Delay slot already parked, so the PC itself moves
                if (redirect) begin
                    pc <= redirectAddr;
                end
            end
        end else if (done) begin
            pc <= target;
            pendingRedirect <= 1'b0;
            if (decodeStall) begin
                state <= cpuPkg::fetchHold;
            end else begin
                state <= cpuPkg::fetchIdle;
                fetchValid <= 1'b1;
            end
        end else begin
            if (instReadEn) begin
                state <= cpuPkg::fetchRequest;
            end
            if (redirect) begin
                pendingRedirect <= 1'b1;
            end
            if (!decodeStall) begin
                fetchValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (redirect && !done) begin
            pendingAddr <= redirectAddr;
        end
        if (state == cpuPkg::fetchHold) begin
            if (!decodeStall) begin
                fetchInst <= holdInst;
                fetchPc <= holdPc;
            end
        end else if (done) begin
            if (decodeStall) begin
                holdInst <= instData;
                holdPc <= pc;
            end else begin
                fetchInst <= instData;
                fetchPc <= pc;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/decode/decoder.sv ====
`default_nettype none
`timescale 1ns/1ns

module decoder (
    input  cpuPkg::word    inst,
    output cpuPkg::regAddr rs,
    output cpuPkg::regAddr rt,
    output cpuPkg::regAddr dest,
    output cpuPkg::word    imm,
    output cpuPkg::aluOp   op,
    output logic           useImm,
    output cpuPkg::wbSrc   src,
    output logic           isBranch,
    output logic           branchNe,
    output logic           isJump,
    output logic           memLoad,
    output logic           memStore,
    output logic           readsRs,
    output logic           readsRt
);

    assign rs = inst[25:21];
    assign rt = inst[20:16];

    always_comb begin
        // Anything not listed below stays a no-op
        dest = 5'd0;
        imm = {{16{inst[15]}}, inst[15:0]};
        op = cpuPkg::aluAdd;
        useImm = 1'b0;
        src = cpuPkg::wbNone;
        isBranch = 1'b0;
        branchNe = 1'b0;
        isJump = 1'b0;
        memLoad = 1'b0;
        memStore = 1'b0;
        readsRs = 1'b0;
        readsRt = 1'b0;
        case (inst[31:26])
            cpuPkg::opSpecial: begin
                dest = inst[15:11];
                src = cpuPkg::wbAlu;
                readsRs = 1'b1;
                readsRt = 1'b1;
                case (inst[5:0])
                    cpuPkg::fnAddu: op = cpuPkg::aluAdd;
                    cpuPkg::fnSubu: op = cpuPkg::aluSub;
                    cpuPkg::fnAnd:  op = cpuPkg::aluAnd;
                    cpuPkg::fnOr:   op = cpuPkg::aluOr;
                    cpuPkg::fnXor:  op = cpuPkg::aluXor;
                    cpuPkg::fnSlt:  op = cpuPkg::aluSlt;
                    default: begin
                        dest = 5'd0;
                        src = cpuPkg::wbNone;
                        readsRs = 1'b0;
                        readsRt = 1'b0;
                    end
                endcase
            end
            cpuPkg::opAddiu: begin
                dest = inst[20:16];
                useImm = 1'b1;
                src = cpuPkg::wbAlu;
                readsRs = 1'b1;
            end
            cpuPkg::opOri: begin
                dest = inst[20:16];
                imm = {16'd0, inst[15:0]};
                op = cpuPkg::aluOr;
                useImm = 1'b1;
                src = cpuPkg::wbAlu;
                readsRs = 1'b1;
            end
            cpuPkg::opLui: begin
                dest = inst[20:16];
                imm = {16'd0, inst[15:0]};
                op = cpuPkg::aluLui;
                useImm = 1'b1;
                src = cpuPkg::wbAlu;
            end
            cpuPkg::opLw: begin
                dest = inst[20:16];
                useImm = 1'b1;
                src = cpuPkg::wbMem;
                memLoad = 1'b1;
                readsRs = 1'b1;
            end
            cpuPkg::opSw: begin
                useImm = 1'b1;
                memStore = 1'b1;
                readsRs = 1'b1;
                readsRt = 1'b1;
            end
            cpuPkg::opBeq, cpuPkg::opBne: begin
                isBranch = 1'b1;
                branchNe = inst[26];
                readsRs = 1'b1;
                readsRt = 1'b1;
            end
            cpuPkg::opJ: begin
                imm = {6'd0, inst[25:0]};
                isJump = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/decode/regFile.sv ====
`default_nettype none
`timescale 1ns/1ns

module regFile (
    input  logic           clk,
    input  logic           reset,
    input  cpuPkg::regAddr readAddr1,
    input  cpuPkg::regAddr readAddr2,
    output cpuPkg::word    readData1,
    output cpuPkg::word    readData2,
    input  cpuPkg::regAddr writeAddr,
    input  cpuPkg::word    writeData
);

    cpuPkg::word regs [32];

    // Zero reads as zero, a same-cycle write is passed through
    function automatic cpuPkg::word readPort(cpuPkg::regAddr addr);
        if (addr == 5'd0) begin
            return '0;
        end
        if (addr == writeAddr) begin
            return writeData;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeAddr != 5'd0) begin
            regs[writeAddr] <= writeData;
        end
    end

    always_comb readData1 = readPort(readAddr1);
    always_comb readData2 = readPort(readAddr2);

endmodule

`default_nettype wire

// ==== hw/decode/forwardUnit.sv ====
`default_nettype none
`timescale 1ns/1ns

module forwardUnit (
    input  cpuPkg::regAddr request,
    input  logic           needed,
    input  cpuPkg::word    fileValue,
    input  cpuPkg::regAddr execDest,
    input  cpuPkg::word    execValue,
    input  logic           execReady,
    input  cpuPkg::regAddr memDest,
    input  cpuPkg::word    memValue,
    output cpuPkg::word    value,
    output logic           hazard
);

    logic execHit;
    logic memHit;

    assign execHit = (execDest != 5'd0) && (execDest == request);
    assign memHit = (memDest != 5'd0) && (memDest == request);

    // Youngest producer first
    assign value = execHit ? execValue : (memHit ? memValue : fileValue);

    // Load result still on its way
    assign hazard = needed && execHit && !execReady;

endmodule

`default_nettype wire

// ==== hw/execute/alu.sv ====
`default_nettype none
`timescale 1ns/1ns

module alu (
    input  cpuPkg::aluOp op,
    input  cpuPkg::word  a,
    input  cpuPkg::word  b,
    output cpuPkg::word  result
);

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            cpuPkg::aluAdd: result = a + b;
            cpuPkg::aluSub: result = a - b;
            cpuPkg::aluAnd: result = a & b;
            cpuPkg::aluOr:  result = a | b;
            cpuPkg::aluXor: result = a ^ b;
            cpuPkg::aluSlt: result = {31'd0, lessThan};
            // Immediate arrives zero-extended
            cpuPkg::aluLui: result = {b[15:0], 16'd0};
            default:        result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/cpuCore.sv ====
`default_nettype none
`timescale 1ns/1ns

module cpuCore #(
    parameter cpuPkg::word resetPc = 32'hBFC00000
) (
    input  logic           clk,
    input  logic           reset,

    output cpuPkg::word    instAddr,
    output logic           instReadEn,
    input  cpuPkg::word    instData,
    input  logic           instValid,

    output cpuPkg::word    dataAddr,
    output logic           dataRead,
    output logic           dataWrite,
    output cpuPkg::word    dataWdata,
    input  cpuPkg::word    dataRdata,
    input  logic           dataValid,

    output cpuPkg::word    wbPc,
    output logic [3:0]     wbRegWen,
    output cpuPkg::regAddr wbRegNum,
    output cpuPkg::word    wbRegData
);

    cpuPkg::word fetchInst;
    cpuPkg::word fetchPc;
    logic fetchValid;
    logic redirect;
    cpuPkg::word redirectAddr;
    logic decodeStall;
    logic hazard;
    logic hazardA;
    logic hazardB;
    logic execWait;

    cpuPkg::regAddr decRs;
    cpuPkg::regAddr decRt;
    cpuPkg::regAddr decDest;
    cpuPkg::word decImm;
    cpuPkg::aluOp decOp;
    logic decUseImm;
    cpuPkg::wbSrc decSrc;
    logic decIsBranch;
    logic decBranchNe;
    logic decIsJump;
    logic decLoad;
    logic decStore;
    logic decReadsRs;
    logic decReadsRt;

    cpuPkg::word fileA;
    cpuPkg::word fileB;
    cpuPkg::word fwdA;
    cpuPkg::word fwdB;
    cpuPkg::word pcPlus4;
    logic taken;

    // Execute stage
    logic exValid;
    cpuPkg::wbSrc exSrc;
    logic exLoad;
    logic exStore;
    cpuPkg::word exPc;
    cpuPkg::aluOp exOp;
    cpuPkg::word exA;
    cpuPkg::word exB;
    cpuPkg::word exStoreData;
    cpuPkg::regAddr exDest;
    cpuPkg::regAddr execFwdDest;
    cpuPkg::word aluResult;

    // Memory/Writeback stage
    logic memValid;
    cpuPkg::wbSrc memSrc;
    cpuPkg::word memPc;
    cpuPkg::regAddr memDest;
    cpuPkg::word memAlu;
    cpuPkg::word memLoadData;
    cpuPkg::regAddr writeAddr;
    cpuPkg::word wbValue;

    instFetch #(
        .resetPc(resetPc)
    ) fetchUnit (
        .clk(clk),
        .reset(reset),
        .redirect(redirect),
        .redirectAddr(redirectAddr),
        .decodeStall(decodeStall),
        .instAddr(instAddr),
        .instReadEn(instReadEn),
        .instData(instData),
        .instValid(instValid),
        .fetchInst(fetchInst),
        .fetchPc(fetchPc),
        .fetchValid(fetchValid)
    );

    decoder decodeUnit (
        .inst(fetchInst),
        .rs(decRs),
        .rt(decRt),
        .dest(decDest),
        .imm(decImm),
        .op(decOp),
        .useImm(decUseImm),
        .src(decSrc),
        .isBranch(decIsBranch),
        .branchNe(decBranchNe),
        .isJump(decIsJump),
        .memLoad(decLoad),
        .memStore(decStore),
        .readsRs(decReadsRs),
        .readsRt(decReadsRt)
    );

    regFile registers (
        .clk(clk),
        .reset(reset),
        .readAddr1(decRs),
        .readAddr2(decRt),
        .readData1(fileA),
        .readData2(fileB),
        .writeAddr(writeAddr),
        .writeData(wbValue)
    );

    // Loads in Execute have no value yet
    assign execFwdDest = (exSrc != cpuPkg::wbNone) ? exDest : 5'd0;

    forwardUnit forwardA (
        .request(decRs),
        .needed(fetchValid && decReadsRs),
        .fileValue(fileA),
        .execDest(execFwdDest),
        .execValue(aluResult),
        .execReady(!exLoad),
        .memDest(writeAddr),
        .memValue(wbValue),
        .value(fwdA),
        .hazard(hazardA)
    );

    forwardUnit forwardB (
        .request(decRt),
        .needed(fetchValid && decReadsRt),
        .fileValue(fileB),
        .execDest(execFwdDest),
        .execValue(aluResult),
        .execReady(!exLoad),
        .memDest(writeAddr),
        .memValue(wbValue),
        .value(fwdB),
        .hazard(hazardB)
    );

    assign hazard = hazardA || hazardB;
    assign execWait = (exLoad || exStore) && !dataValid;
    assign decodeStall = execWait || hazard;

    // Branches resolve here; not taken just falls through
    assign pcPlus4 = fetchPc + 32'd4;
    assign taken = decIsJump || (decIsBranch && ((fwdA == fwdB) != decBranchNe));
    assign redirect = fetchValid && !decodeStall && taken;
    assign redirectAddr = decIsJump ? {pcPlus4[31:28], decImm[25:0], 2'b00}
                                    : pcPlus4 + {decImm[29:0], 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            exValid <= 1'b0;
            exSrc <= cpuPkg::wbNone;
            exLoad <= 1'b0;
            exStore <= 1'b0;
        end else if (!execWait) begin
            if (fetchValid && !hazard) begin
                exValid <= 1'b1;
                exSrc <= decSrc;
                exLoad <= decLoad;
                exStore <= decStore;
            end else begin
                exValid <= 1'b0;
                exSrc <= cpuPkg::wbNone;
                exLoad <= 1'b0;
                exStore <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!execWait) begin
            exPc <= fetchPc;
            exOp <= decOp;
            exA <= fwdA;
            exB <= decUseImm ? decImm : fwdB;
            exStoreData <= fwdB;
            exDest <= decDest;
        end
    end

    alu execAlu (
        .op(exOp),
        .a(exA),
        .b(exB),
        .result(aluResult)
    );

    // Execute registers hold while waiting, so the request stays stable
    assign dataAddr = aluResult;
    assign dataRead = exLoad;
    assign dataWrite = exStore;
    assign dataWdata = exStoreData;

    always_ff @(posedge clk) begin
        if (reset) begin
            memValid <= 1'b0;
            memSrc <= cpuPkg::wbNone;
        end else if (execWait) begin
            memValid <= 1'b0;
            memSrc <= cpuPkg::wbNone;
        end else begin
            memValid <= exValid;
            memSrc <= exSrc;
        end
    end

    always_ff @(posedge clk) begin
        if (exValid && !execWait) begin
            memPc <= exPc;
            memDest <= exDest;
            memAlu <= aluResult;
            memLoadData <= dataRdata;
        end
    end

    assign wbValue = (memSrc == cpuPkg::wbMem) ? memLoadData : memAlu;
    assign writeAddr = (memValid && memSrc != cpuPkg::wbNone) ? memDest : 5'd0;

    assign wbPc = memPc;
    assign wbRegWen = {4{writeAddr != 5'd0}};
    assign wbRegNum = writeAddr;
    assign wbRegData = wbValue;

endmodule

`default_nettype wire

// ==== tests/cpuCore_chk.sv ====
`default_nettype none
`timescale 1ns/1ns

module cpuCoreChk (
    input logic           clk,
    input logic           reset,
    input cpuPkg::word    instAddr,
    input logic           instReadEn,
    input logic           instValid,
    input cpuPkg::word    dataAddr,
    input logic           dataRead,
    input logic           dataWrite,
    input cpuPkg::word    dataWdata,
    input logic           dataValid,
    input logic [3:0]     wbRegWen
);

    instAddrStable: assert property (@(posedge clk) disable iff (reset)
        instReadEn && !instValid |=> $stable(instAddr))
        else $error("instAddr changed while a fetch was waiting");

    dataOneHot: assert property (@(posedge clk) disable iff (reset)
        !(dataRead && dataWrite))
        else $error("dataRead and dataWrite high together");

    dataStable: assert property (@(posedge clk) disable iff (reset)
        (dataRead || dataWrite) && !dataValid |=> $stable(dataAddr) && $stable(dataWdata))
        else $error("data request changed while waiting");

    // Memory stage is flushed by the first reset edge
    wenQuietInReset: assert property (@(posedge clk)
        reset |=> wbRegWen == 4'd0)
        else $error("register write during reset");

endmodule

bind cpuCore cpuCoreChk cpuCoreChk_i (
    .clk(clk),
    .reset(reset),
    .instAddr(instAddr),
    .instReadEn(instReadEn),
    .instValid(instValid),
    .dataAddr(dataAddr),
    .dataRead(dataRead),
    .dataWrite(dataWrite),
    .dataWdata(dataWdata),
    .dataValid(dataValid),
    .wbRegWen(wbRegWen)
);

`default_nettype wire

// ==== tests/cpuTb.sv ====
`default_nettype none
`timescale 1ns/1ns

module cpuTb;

    localparam cpuPkg::word resetPc = 32'hBFC00000;
    localparam int timeoutCycles = 3000;

    logic clk;
    logic reset;
    cpuPkg::word instAddr;
    logic instReadEn;
    cpuPkg::word instData;
    logic instValid;
    cpuPkg::word dataAddr;
    logic dataRead;
    logic dataWrite;
    cpuPkg::word dataWdata;
    cpuPkg::word dataRdata;
    logic dataValid;
    cpuPkg::word wbPc;
    logic [3:0] wbRegWen;
    cpuPkg::regAddr wbRegNum;
    cpuPkg::word wbRegData;

    cpuPkg::word imem [64];
    cpuPkg::word dmem [256];
    int instCount;
    int dataCount;
    bit useRandom;

    // Writeback trace and the list it should match
    int traceNum[$];
    cpuPkg::word traceData[$];
    cpuPkg::word tracePc[$];
    int expNum[$];
    cpuPkg::word expData[$];
    cpuPkg::word expPc[$];

    cpuCore #(
        .resetPc(resetPc)
    ) cpuCore_i (
        .clk(clk),
        .reset(reset),
        .instAddr(instAddr),
        .instReadEn(instReadEn),
        .instData(instData),
        .instValid(instValid),
        .dataAddr(dataAddr),
        .dataRead(dataRead),
        .dataWrite(dataWrite),
        .dataWdata(dataWdata),
        .dataRdata(dataRdata),
        .dataValid(dataValid),
        .wbPc(wbPc),
        .wbRegWen(wbRegWen),
        .wbRegNum(wbRegNum),
        .wbRegData(wbRegData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic cpuPkg::word fetchWord(cpuPkg::word addr);
        cpuPkg::word idx;
        idx = (addr - resetPc) >> 2;
        if (idx < 64) begin
            return imem[idx];
        end
        return '0;
    endfunction

    function automatic int pickLatency();
        if (useRandom) begin
            return $urandom_range(3, 0);
        end
        return 0;
    endfunction

    // Memory answers come a little after the edge
    always @(posedge clk) begin
        #1;
        instValid = (instCount == 0);
        instData = fetchWord(instAddr);
        dataValid = (dataCount == 0);
        dataRdata = dmem[dataAddr[9:2]];
    end

    // Transfers complete at the edge, so account for them midway
    always @(negedge clk) begin
        if (reset) begin
            instCount = 0;
            dataCount = 0;
        end else begin
            if (instReadEn && instValid) begin
                instCount = pickLatency();
            end else if (instReadEn) begin
                instCount = instCount - 1;
            end
            if ((dataRead || dataWrite) && dataValid) begin
                if (dataWrite) begin
                    dmem[dataAddr[9:2]] = dataWdata;
                end
                dataCount = pickLatency();
            end else if (dataRead || dataWrite) begin
                dataCount = dataCount - 1;
            end
            if (wbRegWen != 4'd0) begin
                // Full word write enables all four lanes
                checkValue("wbRegWen", wbRegWen, 32'hF);
                traceNum.push_back(wbRegNum);
                traceData.push_back(wbRegData);
                tracePc.push_back(wbPc);
            end
        end
    end

    task automatic stopRun();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(string name, cpuPkg::word got, cpuPkg::word exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            stopRun();
        end
    endtask

    function automatic cpuPkg::word encodeR(int rs, int rt, int rd, logic [5:0] fn);
        return {cpuPkg::opSpecial, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic cpuPkg::word encodeI(logic [5:0] op, int rs, int rt, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    // Target given as an instruction index from resetPc
    function automatic cpuPkg::word encodeJ(int idx);
        cpuPkg::word addr;
        addr = resetPc + 4 * idx;
        return {cpuPkg::opJ, addr[27:2]};
    endfunction

    function automatic cpuPkg::word encodeBranch(logic [5:0] op, int rs, int rt, int at, int to);
        return encodeI(op, rs, rt, to - at - 1);
    endfunction

    task automatic clearProgram();
        for (int i = 0; i < 64; i++) begin
            imem[i] = '0;
        end
        expNum.delete();
        expData.delete();
        expPc.delete();
    endtask

    task automatic expectWrite(int idx, int num, cpuPkg::word value);
        expNum.push_back(num);
        expData.push_back(value);
        expPc.push_back(resetPc + 4 * idx);
    endtask

    task automatic resetCore();
        @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        traceNum.delete();
        traceData.delete();
        tracePc.delete();
        reset = 1'b0;
    endtask

    task automatic runProgram(bit randomLat);
        int cycles;
        useRandom = randomLat;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = '0;
        end
        resetCore();
        cycles = 0;
        while (traceNum.size() < expNum.size()) begin
            @(posedge clk);
            cycles++;
            if (cycles > timeoutCycles) begin
                $display("Timed out waiting for the writeback trace to complete");
                stopRun();
            end
        end
        // Anything extra would show up here
        repeat (40) @(posedge clk);
        checkValue("trace length", traceNum.size(), expNum.size());
        for (int i = 0; i < expNum.size(); i++) begin
            checkValue("wbRegNum", traceNum[i], expNum[i]);
            checkValue("wbRegData", traceData[i], expData[i]);
            checkValue("wbPc", tracePc[i], expPc[i]);
        end
    endtask

    task automatic runBoth();
        runProgram(1'b0);
        runProgram(1'b1);
    endtask

    task automatic aluChain();
        clearProgram();
        imem[0] = encodeI(cpuPkg::opAddiu, 0, 1, 5);
        imem[1] = encodeI(cpuPkg::opAddiu, 1, 2, 7);
        imem[2] = encodeR(1, 2, 3, cpuPkg::fnAddu);
        imem[3] = encodeR(3, 1, 4, cpuPkg::fnSubu);
        imem[4] = encodeR(3, 1, 5, cpuPkg::fnAnd);
        imem[5] = encodeR(3, 2, 6, cpuPkg::fnOr);
        imem[6] = encodeR(6, 1, 7, cpuPkg::fnXor);
        imem[7] = encodeR(4, 3, 8, cpuPkg::fnSlt);
        imem[8] = encodeI(cpuPkg::opAddiu, 0, 9, -3);
        imem[9] = encodeR(9, 1, 10, cpuPkg::fnSlt);
        imem[10] = encodeI(cpuPkg::opOri, 1, 11, 16'hF0F0);
        imem[11] = encodeI(cpuPkg::opLui, 0, 12, 16'h1234);
        imem[12] = encodeR(12, 11, 13, cpuPkg::fnAddu);
        imem[13] = encodeJ(13);
        expectWrite(0, 1, 32'd5);
        expectWrite(1, 2, 32'd12);
        expectWrite(2, 3, 32'd17);
        expectWrite(3, 4, 32'd12);
        expectWrite(4, 5, 32'd1);
        expectWrite(5, 6, 32'd29);
        expectWrite(6, 7, 32'd29 ^ 32'd5);
        expectWrite(7, 8, 32'd1);
        expectWrite(8, 9, 32'hFFFFFFFD);
        expectWrite(9, 10, 32'd1);
        expectWrite(10, 11, 32'h0000F0F5);
        expectWrite(11, 12, 32'h12340000);
        expectWrite(12, 13, 32'h1234F0F5);
        runBoth();
    endtask

    task automatic storeLoad();
        clearProgram();
        imem[0] = encodeI(cpuPkg::opAddiu, 0, 1, 32'h100);
        imem[1] = encodeI(cpuPkg::opAddiu, 0, 2, 32'h55);
        imem[2] = encodeI(cpuPkg::opSw, 1, 2, 0);
        imem[3] = encodeI(cpuPkg::opLui, 0, 3, 16'hABCD);
        imem[4] = encodeI(cpuPkg::opOri, 3, 3, 16'h1234);
        imem[5] = encodeI(cpuPkg::opSw, 1, 3, 4);
        imem[6] = encodeI(cpuPkg::opAddiu, 0, 4, 32'h1F0);
        imem[7] = encodeI(cpuPkg::opSw, 4, 1, 0);
        imem[8] = encodeI(cpuPkg::opLw, 1, 5, 0);
        imem[9] = encodeR(5, 5, 6, cpuPkg::fnAddu);
        imem[10] = encodeI(cpuPkg::opLw, 1, 7, 4);
        imem[11] = encodeR(7, 3, 8, cpuPkg::fnXor);
        imem[12] = encodeI(cpuPkg::opLw, 4, 9, 0);
        imem[13] = encodeI(cpuPkg::opLw, 9, 10, 0);
        imem[14] = encodeJ(14);
        expectWrite(0, 1, 32'h100);
        expectWrite(1, 2, 32'h55);
        expectWrite(3, 3, 32'hABCD0000);
        expectWrite(4, 3, 32'hABCD1234);
        expectWrite(6, 4, 32'h1F0);
        expectWrite(8, 5, 32'h55);
        expectWrite(9, 6, 32'hAA);
        expectWrite(10, 7, 32'hABCD1234);
        expectWrite(11, 8, 32'h0);
        expectWrite(12, 9, 32'h100);
        expectWrite(13, 10, 32'h55);
        runBoth();
    endtask

    task automatic branches();
        clearProgram();
        imem[0] = encodeI(cpuPkg::opAddiu, 0, 1, 3);
        imem[1] = encodeI(cpuPkg::opAddiu, 0, 2, 3);
        imem[2] = encodeBranch(cpuPkg::opBeq, 1, 2, 2, 6);
        imem[3] = encodeI(cpuPkg::opAddiu, 0, 3, 1);
        imem[4] = encodeI(cpuPkg::opAddiu, 0, 4, 32'h99);
        imem[5] = encodeI(cpuPkg::opAddiu, 0, 4, 32'h98);
        imem[6] = encodeBranch(cpuPkg::opBne, 1, 2, 6, 10);
        imem[7] = encodeI(cpuPkg::opAddiu, 0, 5, 2);
        imem[8] = encodeI(cpuPkg::opAddiu, 0, 6, 4);
        imem[9] = encodeBranch(cpuPkg::opBne, 1, 0, 9, 12);
        imem[10] = encodeI(cpuPkg::opAddiu, 0, 7, 32'h77);
        imem[11] = encodeI(cpuPkg::opAddiu, 0, 8, 32'h66);
        imem[12] = encodeBranch(cpuPkg::opBeq, 1, 0, 12, 15);
        imem[13] = encodeI(cpuPkg::opAddiu, 0, 9, 5);
        imem[14] = encodeI(cpuPkg::opAddiu, 0, 10, 6);
        imem[15] = encodeJ(15);
        expectWrite(0, 1, 32'd3);
        expectWrite(1, 2, 32'd3);
        expectWrite(3, 3, 32'd1);
        expectWrite(7, 5, 32'd2);
        expectWrite(8, 6, 32'd4);
        expectWrite(10, 7, 32'h77);
        expectWrite(13, 9, 32'd5);
        expectWrite(14, 10, 32'd6);
        runBoth();
    endtask

    task automatic jumpForward();
        clearProgram();
        imem[0] = encodeI(cpuPkg::opAddiu, 0, 1, 1);
        imem[1] = encodeJ(5);
        imem[2] = encodeI(cpuPkg::opAddiu, 0, 2, 2);
        imem[3] = encodeI(cpuPkg::opAddiu, 0, 3, 3);
        imem[4] = encodeI(cpuPkg::opAddiu, 0, 3, 4);
        imem[5] = encodeI(cpuPkg::opAddiu, 0, 4, 5);
        imem[6] = encodeJ(6);
        expectWrite(0, 1, 32'd1);
        expectWrite(2, 2, 32'd2);
        expectWrite(5, 4, 32'd5);
        runBoth();
    endtask

    task automatic zeroRegister();
        clearProgram();
        imem[0] = encodeI(cpuPkg::opAddiu, 0, 1, 9);
        imem[1] = encodeI(cpuPkg::opAddiu, 1, 0, 5);
        imem[2] = encodeR(0, 1, 2, cpuPkg::fnAddu);
        imem[3] = encodeR(0, 0, 3, cpuPkg::fnOr);
        imem[4] = encodeJ(4);
        expectWrite(0, 1, 32'd9);
        expectWrite(2, 2, 32'd9);
        expectWrite(3, 3, 32'd0);
        runBoth();
    endtask

    initial begin
        void'($urandom(32'h8ca4b773));
        reset = 1'b1;
        instData = '0;
        instValid = 1'b0;
        dataRdata = '0;
        dataValid = 1'b0;
        instCount = 0;
        dataCount = 0;
        useRandom = 1'b0;
        aluChain();
        storeLoad();
        branches();
        jumpForward();
        zeroRegister();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
common/cpuPkg.sv
hw/fetch/instFetch.sv
hw/decode/decoder.sv
hw/decode/regFile.sv
hw/decode/forwardUnit.sv
hw/execute/alu.sv
hw/cpuCore.sv
tests/cpuCore_chk.sv
tests/cpuTb.sv

// ==== Bender.yml ====
package:
  name: cpuCore

sources:
  - common/cpuPkg.sv
  - hw/fetch/instFetch.sv
  - hw/decode/decoder.sv
  - hw/decode/regFile.sv
  - hw/decode/forwardUnit.sv
  - hw/execute/alu.sv
  - hw/cpuCore.sv
  - target: test
    files:
      - tests/cpuCore_chk.sv
      - tests/cpuTb.sv
